// File: common/power_manager_config.svh
// --------------------
// domain count up to 8, since CTRL and STATUS put the second field at bit 8
// counters are PM_CNT_W bits, so settle and timeout values must fit in them
// --------------------
`ifndef POWER_MANAGER_CONFIG_SVH
`define POWER_MANAGER_CONFIG_SVH

// cpu, peripheral, memory bank 0, memory bank 1
`define PM_NUM_DOMAINS 4

// sequencer step timing
`define PM_SETTLE_CYCLES 4
`define PM_CNT_W 8
`define PM_ACK_TIMEOUT 255

// AXI4-Lite bus widths
`define PM_ADDR_W 8
`define PM_DATA_W 32

// register map
`define PM_REG_CTRL 8'h00
`define PM_REG_STATUS 8'h04
`define PM_REG_PENDING 8'h08
`define PM_REG_IRQ_EN 8'h0C

`endif

// File: common/power_manager_pkg.sv
// --------------------
// types shared by the power manager blocks
// register addresses come from power_manager_config.svh
// --------------------
`include "power_manager_config.svh"

package power_manager_pkg;

  // per-domain sequencer states
  typedef enum logic [3:0] {
    ON      = 4'd0,
    CLK_OFF = 4'd1,
    ISO_ON  = 4'd2,
    RST_ON  = 4'd3,
    SW_OFF  = 4'd4,
    OFF     = 4'd5,
    RET     = 4'd6,
    SW_ON   = 4'd7,
    RST_OFF = 4'd8,
    ISO_OFF = 4'd9,
    CLK_ON  = 4'd10
  } pwr_state_e;

  // mapped register offsets
  typedef enum logic [`PM_ADDR_W-1:0] {
    REG_CTRL    = `PM_REG_CTRL,
    REG_STATUS  = `PM_REG_STATUS,
    REG_PENDING = `PM_REG_PENDING,
    REG_IRQ_EN  = `PM_REG_IRQ_EN
  } reg_addr_e;

  // AXI response codes in use
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axil_resp_e;

endpackage

// File: common/pwr_ctrl_if.sv
// --------------------
// one instance per power domain
// done is a single-cycle pulse
// --------------------
`timescale 1ns/10ps

interface pwr_ctrl_if;

  // software request, from the register block
  logic off_req;
  logic retain;

  // sequencer state summary
  logic is_off;
  logic busy;
  logic done;

  modport regs (
    output off_req,
    output retain
  );

  modport seq (
    input  off_req,
    input  retain,
    output is_off,
    output busy,
    output done
  );

  modport collect (
    input is_off,
    input busy,
    input done
  );

endinterface

// File: hw/domain_sequencer/domain_sequencer.sv
// --------------------
// switch_ack_ni is taken as synchronous, no synchronizer inside
// a missing acknowledge is skipped after PM_ACK_TIMEOUT cycles
// --------------------
`timescale 1ns/10ps
`include "power_manager_config.svh"

module domain_sequencer
  import power_manager_pkg::*;
(
  input  logic    clk_i,
  input  logic    reset_i,
  pwr_ctrl_if.seq ctrl,
  input  logic    switch_ack_ni,
  output logic    switch_no,
  output logic    iso_no,
  output logic    rst_no,
  output logic    clkgate_en_no,
  output logic    retentive_no
);

  localparam logic [`PM_CNT_W-1:0] SETTLE_LAST = `PM_CNT_W'(`PM_SETTLE_CYCLES - 1);
  localparam logic [`PM_CNT_W-1:0] ACK_LIMIT   = `PM_CNT_W'(`PM_ACK_TIMEOUT);

  pwr_state_e             state_q;
  pwr_state_e             state_d;
  logic [`PM_CNT_W-1:0]   settle_cnt_q;
  logic [`PM_CNT_W-1:0]   ack_cnt_q;
  logic                   settle_done;
  logic                   ack_timeout;
  logic                   retain_q;
  logic                   done_q;

  assign settle_done = (settle_cnt_q == SETTLE_LAST);
  assign ack_timeout = (ack_cnt_q == ACK_LIMIT);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ON:      if (ctrl.off_req) state_d = CLK_OFF;
      CLK_OFF: state_d = ISO_ON;
      ISO_ON:  if (settle_done) state_d = RST_ON;
      RST_ON:  if (settle_done) state_d = retain_q ? RET : SW_OFF;
      SW_OFF:  if (switch_ack_ni || ack_timeout) state_d = OFF;
      OFF:     if (!ctrl.off_req) state_d = SW_ON;
      RET: begin
        if (!ctrl.off_req) begin
          state_d = RST_OFF;
        end else if (!ctrl.retain) begin
          // retention dropped while still off, cut the power
          state_d = SW_OFF;
        end
      end
      SW_ON:   if (!switch_ack_ni || ack_timeout) state_d = RST_OFF;
      RST_OFF: if (settle_done) state_d = ISO_OFF;
      ISO_OFF: if (settle_done) state_d = CLK_ON;
      CLK_ON:  state_d = ON;
      default: state_d = ON;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q      <= ON;
      settle_cnt_q <= '0;
      ack_cnt_q    <= '0;
      retain_q     <= 1'b0;
      done_q       <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= (state_d != state_q) && (state_d inside {ON, OFF, RET});

      // both counters restart on every state change
      if (state_d != state_q) begin
        settle_cnt_q <= '0;
      end else if (!settle_done) begin
        settle_cnt_q <= settle_cnt_q + 1'b1;
      end

      if (state_d != state_q || !(state_q inside {SW_OFF, SW_ON})) begin
        ack_cnt_q <= '0;
      end else if (!ack_timeout) begin
        ack_cnt_q <= ack_cnt_q + 1'b1;
      end

      // retain choice is frozen when the power-down starts
      if (state_q == ON) retain_q <= ctrl.retain;
    end
  end

  // active-low controls decoded from the state
  assign clkgate_en_no = state_q inside {ON, CLK_ON};
  assign iso_no        = state_q inside {ON, CLK_OFF, ISO_OFF, CLK_ON};
  assign rst_no        = state_q inside {ON, CLK_OFF, ISO_ON, RST_OFF, ISO_OFF, CLK_ON};
  assign switch_no     = !(state_q inside {SW_OFF, OFF});
  assign retentive_no  = (state_q != RET);

  assign ctrl.is_off = (state_q != ON);
  assign ctrl.busy   = !(state_q inside {ON, OFF, RET});
  assign ctrl.done   = done_q;

  // isolation is already up in the cycle before the switch opens
  a_iso_before_switch: assert property (@(posedge clk_i) disable iff (reset_i)
    !switch_no |-> !iso_no && $past(!iso_no));

  // retention only with the switch closed, entered from a powered state
  a_ret_switch_closed: assert property (@(posedge clk_i) disable iff (reset_i)
    !retentive_no |-> switch_no && $past(switch_no));

endmodule

// File: hw/pwr_status_collect.sv
// --------------------
// set wins over clear when done and clear meet in one cycle
// --------------------
`timescale 1ns/10ps
`include "power_manager_config.svh"

module pwr_status_collect (
  input  logic                            clk_i,
  input  logic                            reset_i,
  pwr_ctrl_if.collect                     ctrl [`PM_NUM_DOMAINS],
  input  logic [`PM_NUM_DOMAINS-1:0]      pending_clr_i,
  input  logic [`PM_NUM_DOMAINS-1:0]      irq_en_i,
  output logic [2*`PM_NUM_DOMAINS-1:0]    status_o,
  output logic [`PM_NUM_DOMAINS-1:0]      pending_o,
  output logic                            irq_o
);

  localparam int N = `PM_NUM_DOMAINS;

  logic [N-1:0] is_off;
  logic [N-1:0] busy;
  logic [N-1:0] done;
  logic [N-1:0] pending_q;

  for (genvar g = 0; g < N; g++) begin : g_dom
    assign is_off[g] = ctrl[g].is_off;
    assign busy[g]   = ctrl[g].busy;
    assign done[g]   = ctrl[g].done;

    // pending only rises on the cycle after that domain's done
    a_pending_after_done: assert property (@(posedge clk_i) disable iff (reset_i)
      $rose(pending_q[g]) |-> $past(done[g]));
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= (pending_q & ~pending_clr_i) | done;
    end
  end

  // busy in the upper half, not-fully-on in the lower
  assign status_o  = {busy, is_off};
  assign pending_o = pending_q;
  assign irq_o     = |(pending_q & irq_en_i);

endmodule

// File: hw/pwr_axil_regs.sv
// --------------------
// single outstanding write and read, AW and W must arrive together
// only byte lanes 0 and 1 are written, others are ignored
// --------------------
`timescale 1ns/10ps
`include "power_manager_config.svh"

module pwr_axil_regs
  import power_manager_pkg::*;
(
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic [`PM_ADDR_W-1:0]           s_awaddr_i,
  input  logic                            s_awvalid_i,
  output logic                            s_awready_o,
  input  logic [`PM_DATA_W-1:0]           s_wdata_i,
  input  logic [`PM_DATA_W/8-1:0]         s_wstrb_i,
  input  logic                            s_wvalid_i,
  output logic                            s_wready_o,
  output logic [1:0]                      s_bresp_o,
  output logic                            s_bvalid_o,
  input  logic                            s_bready_i,
  input  logic [`PM_ADDR_W-1:0]           s_araddr_i,
  input  logic                            s_arvalid_i,
  output logic                            s_arready_o,
  output logic [`PM_DATA_W-1:0]           s_rdata_o,
  output logic [1:0]                      s_rresp_o,
  output logic                            s_rvalid_o,
  input  logic                            s_rready_i,
  pwr_ctrl_if.regs                        ctrl [`PM_NUM_DOMAINS],
  input  logic [2*`PM_NUM_DOMAINS-1:0]    status_i,
  input  logic [`PM_NUM_DOMAINS-1:0]      pending_i,
  output logic [`PM_NUM_DOMAINS-1:0]      pending_clr_o,
  output logic [`PM_NUM_DOMAINS-1:0]      irq_en_o
);

  localparam int N = `PM_NUM_DOMAINS;

  logic [N-1:0]            off_q;
  logic [N-1:0]            retain_q;
  logic [N-1:0]            irq_en_q;
  logic                    bvalid_q;
  axil_resp_e              bresp_q;
  logic                    rvalid_q;
  axil_resp_e              rresp_q;
  logic [`PM_DATA_W-1:0]   rdata_q;
  logic                    wr_fire;
  logic                    rd_fire;
  reg_addr_e               wr_addr;
  reg_addr_e               rd_addr;
  axil_resp_e              wr_resp;
  axil_resp_e              rd_resp;
  logic [`PM_DATA_W-1:0]   rd_data;

  // write takes AW and W in the same cycle, held off while B is pending
  assign wr_fire     = s_awvalid_i && s_wvalid_i && !bvalid_q;
  assign s_awready_o = wr_fire;
  assign s_wready_o  = wr_fire;
  assign wr_addr     = reg_addr_e'(s_awaddr_i);

  assign rd_fire     = s_arvalid_i && !rvalid_q;
  assign s_arready_o = !rvalid_q;
  assign rd_addr     = reg_addr_e'(s_araddr_i);

  // STATUS is read-only and answers like an unmapped offset
  always_comb begin
    case (wr_addr)
      REG_CTRL, REG_PENDING, REG_IRQ_EN: wr_resp = OKAY;
      default:                           wr_resp = SLVERR;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      off_q    <= '0;
      retain_q <= '0;
      irq_en_q <= '0;
    end else if (wr_fire) begin
      if (wr_addr == REG_CTRL) begin
        if (s_wstrb_i[0]) off_q <= s_wdata_i[N-1:0];
        if (s_wstrb_i[1]) retain_q <= s_wdata_i[8 +: N];
      end
      if (wr_addr == REG_IRQ_EN && s_wstrb_i[0]) begin
        irq_en_q <= s_wdata_i[N-1:0];
      end
    end
  end

  // write-1-to-clear, lasts only the accept cycle
  assign pending_clr_o = (wr_fire && wr_addr == REG_PENDING && s_wstrb_i[0]) ?
                         s_wdata_i[N-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bvalid_q <= 1'b0;
    end else if (wr_fire) begin
      bvalid_q <= 1'b1;
    end else if (s_bready_i) begin
      bvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_fire) bresp_q <= wr_resp;
  end

  // read mux
  always_comb begin
    rd_data = '0;
    rd_resp = OKAY;
    case (rd_addr)
      REG_CTRL: begin
        rd_data[N-1:0]  = off_q;
        rd_data[8 +: N] = retain_q;
      end
      REG_STATUS: begin
        rd_data[N-1:0]  = status_i[N-1:0];
        rd_data[8 +: N] = status_i[N +: N];
      end
      REG_PENDING: rd_data[N-1:0] = pending_i;
      REG_IRQ_EN:  rd_data[N-1:0] = irq_en_q;
      default:     rd_resp = SLVERR;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else if (rd_fire) begin
      rvalid_q <= 1'b1;
    end else if (s_rready_i) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_fire) begin
      rdata_q <= rd_data;
      rresp_q <= rd_resp;
    end
  end

  assign s_bvalid_o = bvalid_q;
  assign s_bresp_o  = bresp_q;
  assign s_rvalid_o = rvalid_q;
  assign s_rresp_o  = rresp_q;
  assign s_rdata_o  = rdata_q;
  assign irq_en_o   = irq_en_q;

  // fan CTRL out to the domains
  for (genvar g = 0; g < N; g++) begin : g_ctrl
    assign ctrl[g].off_req = off_q[g];
    assign ctrl[g].retain  = retain_q[g];
  end

  // responses hold with stable payload until accepted
  a_bvalid_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o));

  a_rvalid_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o) && $stable(s_rresp_o));

endmodule

// File: hw/power_manager_top.sv
// --------------------
// switch_ack_ni must be synchronous to clk_i
// all domains are sequenced alike, any one may retain
// --------------------
`timescale 1ns/10ps
`include "power_manager_config.svh"

module power_manager_top (
  input  logic                            clk_i,
  input  logic                            reset_i,
  // AXI4-Lite slave
  input  logic [`PM_ADDR_W-1:0]           s_awaddr_i,
  input  logic                            s_awvalid_i,
  output logic                            s_awready_o,
  input  logic [`PM_DATA_W-1:0]           s_wdata_i,
  input  logic [`PM_DATA_W/8-1:0]         s_wstrb_i,
  input  logic                            s_wvalid_i,
  output logic                            s_wready_o,
  output logic [1:0]                      s_bresp_o,
  output logic                            s_bvalid_o,
  input  logic                            s_bready_i,
  input  logic [`PM_ADDR_W-1:0]           s_araddr_i,
  input  logic                            s_arvalid_i,
  output logic                            s_arready_o,
  output logic [`PM_DATA_W-1:0]           s_rdata_o,
  output logic [1:0]                      s_rresp_o,
  output logic                            s_rvalid_o,
  input  logic                            s_rready_i,
  // domain power controls, all active low
  input  logic [`PM_NUM_DOMAINS-1:0]      switch_ack_ni,
  output logic [`PM_NUM_DOMAINS-1:0]      switch_no,
  output logic [`PM_NUM_DOMAINS-1:0]      iso_no,
  output logic [`PM_NUM_DOMAINS-1:0]      rst_no,
  output logic [`PM_NUM_DOMAINS-1:0]      clkgate_en_no,
  output logic [`PM_NUM_DOMAINS-1:0]      retentive_no,
  output logic                            irq_o
);

  pwr_ctrl_if ctrl_if [`PM_NUM_DOMAINS] ();

  logic [2*`PM_NUM_DOMAINS-1:0] status;
  logic [`PM_NUM_DOMAINS-1:0]   pending;
  logic [`PM_NUM_DOMAINS-1:0]   pending_clr;
  logic [`PM_NUM_DOMAINS-1:0]   irq_en;

  pwr_axil_regs pwr_axil_regs_i (
    .clk_i,
    .reset_i,
    .s_awaddr_i,
    .s_awvalid_i,
    .s_awready_o,
    .s_wdata_i,
    .s_wstrb_i,
    .s_wvalid_i,
    .s_wready_o,
    .s_bresp_o,
    .s_bvalid_o,
    .s_bready_i,
    .s_araddr_i,
    .s_arvalid_i,
    .s_arready_o,
    .s_rdata_o,
    .s_rresp_o,
    .s_rvalid_o,
    .s_rready_i,
    .ctrl          (ctrl_if),
    .status_i      (status),
    .pending_i     (pending),
    .pending_clr_o (pending_clr),
    .irq_en_o      (irq_en)
  );

  for (genvar g = 0; g < `PM_NUM_DOMAINS; g++) begin : g_domain
    domain_sequencer domain_sequencer_i (
      .clk_i,
      .reset_i,
      .ctrl          (ctrl_if[g]),
      .switch_ack_ni (switch_ack_ni[g]),
      .switch_no     (switch_no[g]),
      .iso_no        (iso_no[g]),
      .rst_no        (rst_no[g]),
      .clkgate_en_no (clkgate_en_no[g]),
      .retentive_no  (retentive_no[g])
    );
  end

  pwr_status_collect pwr_status_collect_i (
    .clk_i,
    .reset_i,
    .ctrl          (ctrl_if),
    .pending_clr_i (pending_clr),
    .irq_en_i      (irq_en),
    .status_o      (status),
    .pending_o     (pending),
    .irq_o
  );

endmodule

// File: tb/tb_power_manager.sv
// --------------------
// switch_ack_ni model is the inverse of switch_no, 3 cycles late
// stops at the first failing check
// --------------------
`timescale 1ns/10ps
`include "power_manager_config.svh"

module tb_power_manager;

  localparam int N = `PM_NUM_DOMAINS;
  localparam int AXI_LIMIT = 50;
  localparam int POWER_LIMIT = 600;
  localparam int POLL_LIMIT = 200;
  // {switch_no, iso_no, rst_no, clkgate_en_no, retentive_no}
  localparam logic [4:0] CTL_ON  = 5'b11111;
  localparam logic [4:0] CTL_OFF = 5'b00001;
  localparam logic [4:0] CTL_RET = 5'b10000;

  logic                  clk_i;
  logic                  reset_i;
  logic [`PM_ADDR_W-1:0] s_awaddr_i;
  logic                  s_awvalid_i;
  logic                  s_awready_o;
  logic [`PM_DATA_W-1:0] s_wdata_i;
  logic [3:0]            s_wstrb_i;
  logic                  s_wvalid_i;
  logic                  s_wready_o;
  logic [1:0]            s_bresp_o;
  logic                  s_bvalid_o;
  logic                  s_bready_i;
  logic [`PM_ADDR_W-1:0] s_araddr_i;
  logic                  s_arvalid_i;
  logic                  s_arready_o;
  logic [`PM_DATA_W-1:0] s_rdata_o;
  logic [1:0]            s_rresp_o;
  logic                  s_rvalid_o;
  logic                  s_rready_i;
  logic [N-1:0]          switch_ack_ni;
  logic [N-1:0]          switch_no;
  logic [N-1:0]          iso_no;
  logic [N-1:0]          rst_no;
  logic [N-1:0]          clkgate_en_no;
  logic [N-1:0]          retentive_no;
  logic                  irq_o;
  logic [N-1:0]          ack_pipe [3];

  power_manager_top DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // ack_ni stays low while the domain is powered
  initial begin
    ack_pipe[0] = '0;
    ack_pipe[1] = '0;
    ack_pipe[2] = '0;
    switch_ack_ni = '0;
    forever begin
      @(posedge clk_i);
      #2;
      switch_ack_ni = ack_pipe[2];
      ack_pipe[2] = ack_pipe[1];
      ack_pipe[1] = ack_pipe[0];
      ack_pipe[0] = ~switch_no;
    end
  end

  task automatic stop_on_failure(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string test, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("[ERROR] %s %s: expected 0x%0h, actual 0x%0h", test, what, exp, act);
      $display("Test failures found");
      $fatal(1, "simulation stopped");
    end
  endtask

  // isolation must be up before any switch opens
  initial begin : iso_order_monitor
    logic [N-1:0] prev_sw;
    logic [N-1:0] prev_iso;
    prev_sw  = '1;
    prev_iso = '1;
    forever begin
      @(posedge clk_i);
      #1;
      for (int d = 0; d < N; d++) begin
        if (prev_sw[d] && !switch_no[d]) begin
          assert (!prev_iso[d]) else
            stop_on_failure($sformatf("domain %0d opened its switch before isolation", d));
        end
      end
      prev_sw  = switch_no;
      prev_iso = iso_no;
    end
  end

  task automatic step_clock();
    @(posedge clk_i);
    #2;
  endtask

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    int count;
    count       = 0;
    s_awaddr_i  = addr;
    s_wdata_i   = data;
    s_wstrb_i   = 4'hF;
    s_awvalid_i = 1'b1;
    s_wvalid_i  = 1'b1;
    s_bready_i  = 1'b1;
    #1;
    while (!(s_awready_o && s_wready_o)) begin
      step_clock();
      #1;
      count++;
      if (count > AXI_LIMIT) stop_on_failure("write was never accepted");
    end
    step_clock();
    s_awvalid_i = 1'b0;
    s_wvalid_i  = 1'b0;
    count = 0;
    while (!s_bvalid_o) begin
      step_clock();
      count++;
      if (count > AXI_LIMIT) stop_on_failure("write response never arrived");
    end
    resp = s_bresp_o;
    step_clock();
    s_bready_i = 1'b0;
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int count;
    count       = 0;
    s_araddr_i  = addr;
    s_arvalid_i = 1'b1;
    s_rready_i  = 1'b1;
    #1;
    while (!s_arready_o) begin
      step_clock();
      #1;
      count++;
      if (count > AXI_LIMIT) stop_on_failure("read address was never accepted");
    end
    step_clock();
    s_arvalid_i = 1'b0;
    count = 0;
    while (!s_rvalid_o) begin
      step_clock();
      count++;
      if (count > AXI_LIMIT) stop_on_failure("read data never arrived");
    end
    data = s_rdata_o;
    resp = s_rresp_o;
    step_clock();
    s_rready_i = 1'b0;
  endtask

  task automatic write_ok(input string test, input logic [7:0] addr,
                          input logic [31:0] data);
    logic [1:0] resp;
    axi_write(addr, data, resp);
    check_value(test, $sformatf("write resp at 0x%0h", addr), 32'h0, resp);
  endtask

  task automatic expect_read(input string test, input string what,
                             input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] data;
    logic [1:0]  resp;
    axi_read(addr, data, resp);
    check_value(test, {what, " resp"}, 32'h0, resp);
    check_value(test, what, exp, data);
  endtask

  task automatic wait_irq(input string test);
    int count;
    count = 0;
    while (!irq_o) begin
      step_clock();
      count++;
      if (count > POWER_LIMIT) stop_on_failure({test, ": irq_o never rose"});
    end
  endtask

  task automatic wait_pending(input string test, input logic [31:0] mask);
    logic [31:0] data;
    logic [1:0]  resp;
    int          count;
    count = 0;
    axi_read(`PM_REG_PENDING, data, resp);
    while ((data & mask) != mask) begin
      count++;
      if (count > POLL_LIMIT) stop_on_failure({test, ": pending bits never set"});
      axi_read(`PM_REG_PENDING, data, resp);
    end
  endtask

  task automatic check_controls(input string test, input int d, input logic [4:0] exp);
    check_value(test, $sformatf("domain %0d controls", d), {27'b0, exp},
                {27'b0, switch_no[d], iso_no[d], rst_no[d], clkgate_en_no[d],
                 retentive_no[d]});
  endtask

  task automatic test_reset();
    for (int d = 0; d < N; d++) check_controls("reset", d, CTL_ON);
    check_value("reset", "irq_o", 32'h0, {31'b0, irq_o});
    expect_read("reset", "CTRL", `PM_REG_CTRL, 32'h0);
    expect_read("reset", "STATUS", `PM_REG_STATUS, 32'h0);
    expect_read("reset", "PENDING", `PM_REG_PENDING, 32'h0);
    expect_read("reset", "IRQ_EN", `PM_REG_IRQ_EN, 32'h0);
  endtask

  task automatic test_registers();
    logic [31:0] data;
    logic [1:0]  resp;
    // retain bits alone start no transition
    write_ok("registers", `PM_REG_CTRL, 32'h0000_0500);
    expect_read("registers", "CTRL", `PM_REG_CTRL, 32'h0000_0500);
    write_ok("registers", `PM_REG_CTRL, 32'h0);
    write_ok("registers", `PM_REG_IRQ_EN, 32'h0000_000A);
    expect_read("registers", "IRQ_EN", `PM_REG_IRQ_EN, 32'h0000_000A);
    write_ok("registers", `PM_REG_IRQ_EN, 32'h0);
    axi_write(`PM_REG_STATUS, 32'h0000_0F0F, resp);
    check_value("registers", "STATUS write resp", 32'h2, resp);
    expect_read("registers", "STATUS", `PM_REG_STATUS, 32'h0);
    axi_read(8'h10, data, resp);
    check_value("registers", "unmapped read resp", 32'h2, resp);
  endtask

  task automatic test_power_down();
    write_ok("power_down", `PM_REG_IRQ_EN, 32'h2);
    write_ok("power_down", `PM_REG_CTRL, 32'h2);
    wait_irq("power_down");
    check_controls("power_down", 1, CTL_OFF);
    for (int d = 0; d < N; d++) begin
      if (d != 1) check_controls("power_down", d, CTL_ON);
    end
    expect_read("power_down", "STATUS", `PM_REG_STATUS, 32'h2);
    expect_read("power_down", "PENDING", `PM_REG_PENDING, 32'h2);
  endtask

  task automatic test_power_up();
    write_ok("power_up", `PM_REG_PENDING, 32'h2);
    check_value("power_up", "irq_o after clear", 32'h0, {31'b0, irq_o});
    write_ok("power_up", `PM_REG_CTRL, 32'h0);
    wait_pending("power_up", 32'h2);
    for (int d = 0; d < N; d++) check_controls("power_up", d, CTL_ON);
    expect_read("power_up", "STATUS", `PM_REG_STATUS, 32'h0);
    check_value("power_up", "irq_o", 32'h1, {31'b0, irq_o});
    write_ok("power_up", `PM_REG_PENDING, 32'h2);
    expect_read("power_up", "PENDING", `PM_REG_PENDING, 32'h0);
    check_value("power_up", "irq_o after clear", 32'h0, {31'b0, irq_o});
  endtask

  task automatic test_retention();
    write_ok("retention", `PM_REG_CTRL, 32'h0000_0404);
    wait_pending("retention", 32'h4);
    check_controls("retention", 2, CTL_RET);
    expect_read("retention", "STATUS", `PM_REG_STATUS, 32'h4);
    write_ok("retention", `PM_REG_PENDING, 32'h4);
    write_ok("retention", `PM_REG_CTRL, 32'h0);
    wait_pending("retention", 32'h4);
    for (int d = 0; d < N; d++) check_controls("retention", d, CTL_ON);
    expect_read("retention", "STATUS", `PM_REG_STATUS, 32'h0);
    write_ok("retention", `PM_REG_PENDING, 32'h4);
  endtask

  task automatic test_independent();
    logic [31:0] mask;
    logic [31:0] en;
    mask = ($urandom % ((1 << N) - 1)) + 1;
    en   = $urandom & ((1 << N) - 1);
    write_ok("independent", `PM_REG_IRQ_EN, en);
    write_ok("independent", `PM_REG_CTRL, mask);
    wait_pending("independent", mask);
    expect_read("independent", "PENDING", `PM_REG_PENDING, mask);
    for (int d = 0; d < N; d++) begin
      check_controls("independent", d, mask[d] ? CTL_OFF : CTL_ON);
    end
    expect_read("independent", "STATUS", `PM_REG_STATUS, mask);
    check_value("independent", "irq_o", {31'b0, |(mask & en)}, {31'b0, irq_o});
    write_ok("independent", `PM_REG_PENDING, mask);
    check_value("independent", "irq_o after clear", 32'h0, {31'b0, irq_o});
    write_ok("independent", `PM_REG_CTRL, 32'h0);
    wait_pending("independent", mask);
    for (int d = 0; d < N; d++) check_controls("independent", d, CTL_ON);
    expect_read("independent", "STATUS", `PM_REG_STATUS, 32'h0);
    write_ok("independent", `PM_REG_PENDING, mask);
  endtask

  initial begin
    void'($urandom(32'h8b7e_09ad));
    reset_i     = 1'b1;
    s_awaddr_i  = '0;
    s_awvalid_i = 1'b0;
    s_wdata_i   = '0;
    s_wstrb_i   = '0;
    s_wvalid_i  = 1'b0;
    s_bready_i  = 1'b0;
    s_araddr_i  = '0;
    s_arvalid_i = 1'b0;
    s_rready_i  = 1'b0;
    repeat (4) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    test_reset();
    test_registers();
    test_power_down();
    test_power_up();
    test_retention();
    test_independent();
    $display("All tests passed!");
    $finish;
  end

endmodule

// File: src.f
+incdir+common
common/power_manager_pkg.sv
common/pwr_ctrl_if.sv
hw/domain_sequencer/domain_sequencer.sv
hw/pwr_status_collect.sv
hw/pwr_axil_regs.sv
hw/power_manager_top.sv
tb/tb_power_manager.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the power manager testbench with Verilator, run it, check the log
set -e

cd "$(dirname "$0")"

rm -rf build
verilator --binary --timing --assert -Wno-fatal \
  -f src.f --top-module tb_power_manager -Mdir build -o sim

# the simulation exit code is not trusted, the log decides
./build/sim > sim.log 2>&1 || true
cat sim.log

if grep -q 'All tests passed!' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
